// ==== build.f ====
common/obj_pkg.sv
source/obj_line_match.sv
queue/obj_pri_queue.sv
source/obj_slice_draw.sv
linebuf/obj_line_buffer.sv
source/obj_seq_ctrl.sv
source/obj_render_top.sv
test/tb_clock_gen.sv
test/tb_obj_render.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_obj_render -f build.f -o tb_obj_render

# the simulation status is not trusted, the output decides
sim_out=$(./obj_dir/tb_obj_render || true)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== test/tb_obj_render.sv ====
module tb_obj_render
    import obj_pkg::*;
();

    localparam int LINE_CYCLES    = 2048;  // 512 pixels of 4 clocks
    localparam int TIMEOUT_CYCLES = 14 * LINE_CYCLES + 4096;

    logic                   CLK96;
    logic                   RESET96 = 1'b1;
    logic [10:0]            tcnt = '0;       // clock position inside the line
    logic                   pixel_cen = 1'b0;
    logic [LINE_W-1:0]      h_cnt = '0;
    logic                   hb = 1'b0;
    logic                   vb = 1'b0;
    logic                   active = 1'b1;
    logic [LINE_W-1:0]      vrender = '0;
    logic [LINE_W-1:0]      scroll_x = '0;
    logic [LINE_W-1:0]      scroll_y = '0;
    logic [RAM_ADDR_W-1:0]  ram_addr_a, ram_addr_b;
    logic [RAM_DATA_W-1:0]  ram_data_a = '0;
    logic [RAM_DATA_W-1:0]  ram_data_b = '0;
    logic                   gfx_cs, gfx_ok = 1'b0;
    logic [TILE_NUM_W-1:0]  tile_num;
    logic [TILE_OFFS_W-1:0] tile_offs;
    logic [SLICE_W-1:0]     gfx_data = '0;
    logic [PIX_W-1:0]       obj_pixel;

    logic [RAM_DATA_W-1:0]  sram [SPR_COUNT*4];
    logic [SLICE_W-1:0]     gfx_rom [256];
    logic [PIX_W-1:0]       exp_line [VIS_WIDTH];
    int                     gfx_wait = 3;
    int                     cycles = 0;
    int                     pix_errors = 0;
    int                     tests_run = 0;
    int                     tests_passed = 0;
    logic                   checking = 1'b0;
    logic                   rd_valid = 1'b0;
    logic [LINE_W-1:0]      rd_col = '0;
    string                  test_name = "";

    tb_clock_gen #(.PERIOD(8)) u_clk (.clk_o(CLK96));

    obj_render_top obj_render_top_inst (
        .clk96_i(CLK96), .reset96_i(RESET96), .pixel_cen_i(pixel_cen), .vrender_i(vrender),
        .h_i(h_cnt), .hb_i(hb), .vb_i(vb), .active_i(active),
        .sprite_scroll_x_i(scroll_x), .sprite_scroll_y_i(scroll_y),
        .ram_addr_a_o(ram_addr_a), .ram_data_a_i(ram_data_a),
        .ram_addr_b_o(ram_addr_b), .ram_data_b_i(ram_data_b),
        .gfx_cs_o(gfx_cs), .gfx_ok_i(gfx_ok), .tile_num_o(tile_num), .tile_offs_o(tile_offs),
        .gfx_data_i(gfx_data), .obj_pixel_o(obj_pixel)
    );

    // 320 active pixels then blank
    // pixel enable on the last clock of each pixel
    always @(posedge CLK96) begin
        tcnt <= tcnt + 11'd1;
        h_cnt <= LINE_W'((tcnt + 11'd1) >> 2);
        pixel_cen <= (tcnt[1:0] == 2'd2);
        hb <= ((tcnt + 11'd1) >> 2) >= 11'(VIS_WIDTH);
        active <= ((tcnt + 11'd1) >> 2) < 11'(VIS_WIDTH);
    end

    // RAM stage behind the registered DUT address
    always @(posedge CLK96) begin
        ram_data_a <= sram[ram_addr_a[9:0]];
        ram_data_b <= sram[ram_addr_b[9:0]];
    end

    function automatic logic [SLICE_W-1:0] tile_slice(input logic [TILE_NUM_W-1:0] tile,
                                                      input logic [TILE_OFFS_W-1:0] offs);
        return gfx_rom[(int'(tile) * 13 + int'(offs) / 4) % 256];
    endfunction

    always @(posedge CLK96) begin
        if (gfx_ok) begin
            gfx_ok <= 1'b0;                     // taken on this edge
            gfx_wait <= $urandom_range(5, 0);
        end else if (gfx_cs) begin
            if (gfx_wait == 0) begin
                gfx_ok <= 1'b1;
                gfx_data <= tile_slice(tile_num, tile_offs);
            end else begin
                gfx_wait <= gfx_wait - 1;
            end
        end
    end

    // pixel register is compared half a clock after the read edge
    always @(posedge CLK96) begin
        rd_valid <= pixel_cen && active && checking;
        rd_col <= h_cnt;
    end

    always @(negedge CLK96) begin
        if (rd_valid) begin
            a_pixel: assert (obj_pixel == exp_line[rd_col]) else begin
                $display("error %s col %0d expected %04h actual %04h",
                         test_name, rd_col, exp_line[rd_col], obj_pixel);
                pix_errors++;
            end
        end
    end

    always @(posedge CLK96) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the line sequence did not complete", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic wait_count(input logic [10:0] target);
        do @(posedge CLK96); while (tcnt != target);
    endtask

    // inactive entries still carry an address dependent pattern
    task automatic clear_sprites();
        logic [RAM_DATA_W-1:0] pattern;
        for (int a = 0; a < SPR_COUNT * 4; a++) begin
            pattern = RAM_DATA_W'(a * 40503 + 7);
            if (a % 4 == 0) pattern[15] = 1'b0;
            sram[a] <= pattern;
        end
    endtask

    task automatic load_sprite(input int idx, input logic flip, input logic [3:0] pri,
                               input logic [5:0] pal, input logic [14:0] tile,
                               input logic [8:0] xpos, input logic [3:0] xsize,
                               input logic [8:0] ypos, input logic [3:0] ysize);
        sram[idx * 4]     <= {1'b1, 2'b00, flip, pri, pal, 2'b00};
        sram[idx * 4 + 1] <= {1'b0, tile};
        sram[idx * 4 + 2] <= {xpos, 3'b000, xsize};
        sram[idx * 4 + 3] <= {ypos, 3'b000, ysize};
    endtask

    task automatic set_view(input int line, input int sx, input int sy);
        vrender <= LINE_W'(line);
        scroll_x <= LINE_W'(sx);
        scroll_y <= LINE_W'(sy);
    endtask

    // later levels are drawn over earlier ones
    task automatic build_expected();
        logic [RAM_DATA_W-1:0] w0, w1, w2, w3;
        logic [SLICE_W-1:0]    slice;
        int y, r, x, wt, offs, sc, nib, col;
        for (int c = 0; c < VIS_WIDTH; c++) exp_line[c] = '0;
        for (int pri = 0; pri < PRI_LEVELS; pri++) begin
            for (int s = 0; s < SPR_COUNT; s++) begin
                w0 = sram[s * 4];
                w1 = sram[s * 4 + 1];
                w2 = sram[s * 4 + 2];
                w3 = sram[s * 4 + 3];
                if (!w0[15] || int'(w0[11:8]) != pri) continue;
                y = (int'(w3[15:7]) + int'(scroll_y)) % 512;
                if (int'(vrender) < y || int'(vrender) >= y + (int'(w3[3:0]) + 1) * 8) continue;
                r = int'(vrender) - y;
                x = (int'(w2[15:7]) + int'(scroll_x)) % 512;
                if (x > 384) x = x - 512;  // far right wraps to the left edge
                wt = int'(w2[3:0]) + 1;
                for (int t = 0; t < wt; t++) begin
                    offs = (r / 8) * wt * 32 + (r % 8) * 4 + t * 32;
                    slice = tile_slice(w1[14:0], TILE_OFFS_W'(offs));
                    sc = w0[12] ? wt - 1 - t : t;
                    for (int p = 0; p < 8; p++) begin
                        nib = int'(slice >> (4 * (w0[12] ? 7 - p : p))) & 15;
                        col = x + sc * 8 + p;
                        if (nib != 0 && col >= 0 && col < VIS_WIDTH)
                            exp_line[col] = {w0[11:8], w0[7:2], 4'(nib)};
                    end
                end
            end
        end
    endtask

    // render during one line and compare during the next
    task automatic run_line_test(input string name);
        int   err_start;
        logic busy;
        @(posedge CLK96);
        build_expected();
        err_start = pix_errors;
        test_name = name;
        wait_count(11'd2047);
        wait_count(11'd1300);
        busy = (obj_render_top_inst.u_seq.state != S_IDLE);
        a_render_done: assert (!busy) else
            $display("test %s: sprite render still running at the start of blank", name);
        wait_count(11'd2047);
        checking <= 1'b1;  // halves swap on this blank edge
        wait_count(11'd1300);
        checking <= 1'b0;
        tests_run++;
        if (!busy && pix_errors == err_start) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d pixel errors", name, pix_errors - err_start);
        end
    endtask

    initial begin
        logic [SLICE_W-1:0] word;
        logic [3:0]         nib;
        void'($urandom(32'haba7e3e8));
        for (int i = 0; i < 256; i++) begin
            word = '0;
            for (int n = 0; n < 8; n++) begin
                nib = 4'($urandom_range(15, 1));
                if ($urandom_range(3, 0) == 0) nib = 4'd0;  // some transparent pixels
                word[n * 4 +: 4] = nib;
            end
            gfx_rom[i] = word;
        end
        clear_sprites();
        repeat (10) @(posedge CLK96);
        RESET96 <= 1'b0;
        wait_count(11'd1300);

        clear_sprites();
        set_view(40, 0, 0);
        run_line_test("no_sprites");

        clear_sprites();
        load_sprite(5, 1'b0, 4'd3, 6'h15, 15'h0123, 9'd100, 4'd0, 9'd30, 4'd0);
        set_view(40, 20, 6);
        run_line_test("single");

        clear_sprites();
        load_sprite(5, 1'b1, 4'd3, 6'h15, 15'h0123, 9'd100, 4'd0, 9'd30, 4'd0);
        set_view(40, 20, 6);
        run_line_test("xflip");

        // lower index on the higher level so level order and index order differ
        clear_sprites();
        load_sprite(10, 1'b0, 4'd7, 6'h03, 15'h0200, 9'd150, 4'd1, 9'd96, 4'd1);
        load_sprite(20, 1'b0, 4'd2, 6'h2a, 15'h0310, 9'd158, 4'd0, 9'd90, 4'd1);
        set_view(100, 0, 0);
        run_line_test("priority");

        for (int k = 0; k < 2; k++) begin
            clear_sprites();
            load_sprite(30, 1'b0, 4'd4, 6'h11, 15'h0400, 9'd50, 4'd0, 9'd152, 4'd2);
            load_sprite(31, 1'b1, 4'd5, 6'h22, 15'h0500, 9'd312, 4'd2, 9'd192, 4'd1);
            load_sprite(32, 1'b0, 4'd9, 6'h33, 15'h0600, 9'd6, 4'd1, 9'd198, 4'd0);
            set_view(200, 500, 510);
            if (k == 0) begin
                run_line_test("clip_wrap");
            end else begin
                run_line_test("clip_wrap_rerun");
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, pixel errors %0d",
                 tests_run, tests_passed, tests_run - tests_passed, pix_errors);
        if (tests_passed == tests_run) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD / 2) clk_o = ~clk_o;  // half period high, half low

endmodule

// ==== source/obj_render_top.sv ====
module obj_render_top
    import obj_pkg::*;
(
    input  logic                   clk96_i,
    input  logic                   reset96_i,
    input  logic                   pixel_cen_i,
    input  logic [LINE_W-1:0]      vrender_i,
    input  logic [LINE_W-1:0]      h_i,
    input  logic                   hb_i,
    input  logic                   vb_i,
    input  logic                   active_i,
    input  logic [LINE_W-1:0]      sprite_scroll_x_i,
    input  logic [LINE_W-1:0]      sprite_scroll_y_i,
    output logic [RAM_ADDR_W-1:0]  ram_addr_a_o,
    input  logic [RAM_DATA_W-1:0]  ram_data_a_i,
    output logic [RAM_ADDR_W-1:0]  ram_addr_b_o,
    input  logic [RAM_DATA_W-1:0]  ram_data_b_i,
    output logic                   gfx_cs_o,
    input  logic                   gfx_ok_i,
    output logic [TILE_NUM_W-1:0]  tile_num_o,
    output logic [TILE_OFFS_W-1:0] tile_offs_o,
    input  logic [SLICE_W-1:0]     gfx_data_i,
    output logic [PIX_W-1:0]       obj_pixel_o
);

    logic                   match, q_push, q_clear, q_empty;
    logic [PRI_W-1:0]       match_pri, q_level, q_first_pri;
    logic [SPR_IDX_W-1:0]   q_push_sprite, q_sprite;
    logic [SPR_IDX_W:0]     q_rd_idx, q_count;
    logic                   slice_load, slice_xflip, slice_done;
    logic signed [LINE_W:0] slice_x;
    logic [PRI_W+PAL_W-1:0] slice_attr;
    logic                   lb_wr_en;
    logic [LINE_W-1:0]      lb_wr_addr;
    logic [PIX_W-1:0]       lb_wr_data;

    obj_seq_ctrl u_seq (
        .clk96_i(clk96_i), .reset96_i(reset96_i), .hb_i(hb_i), .vb_i(vb_i),
        .vrender_i(vrender_i), .ram_data_a_i(ram_data_a_i), .ram_data_b_i(ram_data_b_i),
        .sprite_scroll_x_i(sprite_scroll_x_i), .sprite_scroll_y_i(sprite_scroll_y_i),
        .match_i(match), .match_pri_i(match_pri), .q_empty_i(q_empty),
        .q_pri_i(q_first_pri), .q_count_i(q_count), .q_sprite_i(q_sprite),
        .gfx_ok_i(gfx_ok_i), .slice_done_i(slice_done),
        .ram_addr_a_o(ram_addr_a_o), .ram_addr_b_o(ram_addr_b_o),
        .q_push_o(q_push), .q_sprite_o(q_push_sprite), .q_rd_pri_o(q_level),
        .q_rd_idx_o(q_rd_idx), .q_clear_o(q_clear), .gfx_cs_o(gfx_cs_o),
        .tile_num_o(tile_num_o), .tile_offs_o(tile_offs_o), .slice_load_o(slice_load),
        .slice_xflip_o(slice_xflip), .slice_x_o(slice_x), .slice_attr_o(slice_attr)
    );

    obj_line_match u_match (
        .word0_i(ram_data_a_i), .word3_i(ram_data_b_i), .vrender_i(vrender_i),
        .sprite_scroll_y_i(sprite_scroll_y_i), .match_o(match), .pri_o(match_pri)
    );

    // one level bus, push level while scanning and read level while drawing
    obj_pri_queue u_queue (
        .clk96_i(clk96_i), .reset96_i(reset96_i), .clear_i(q_clear), .push_i(q_push),
        .push_pri_i(q_level), .push_sprite_i(q_push_sprite), .rd_pri_i(q_level),
        .rd_idx_i(q_rd_idx), .empty_o(q_empty), .first_pri_o(q_first_pri),
        .count_o(q_count), .sprite_o(q_sprite)
    );

    obj_slice_draw u_draw (
        .clk96_i(clk96_i), .reset96_i(reset96_i), .load_i(slice_load), .slice_i(gfx_data_i),
        .xflip_i(slice_xflip), .x_base_i(slice_x), .attr_i(slice_attr),
        .done_o(slice_done), .wr_en_o(lb_wr_en), .wr_addr_o(lb_wr_addr), .wr_data_o(lb_wr_data)
    );

    obj_line_buffer u_linebuf (
        .clk96_i(clk96_i), .reset96_i(reset96_i), .hb_i(hb_i), .pixel_cen_i(pixel_cen_i),
        .active_i(active_i), .wr_en_i(lb_wr_en), .wr_addr_i(lb_wr_addr),
        .wr_data_i(lb_wr_data), .rd_addr_i(h_i), .pixel_o(obj_pixel_o)
    );

endmodule

// ==== source/obj_seq_ctrl.sv ====
module obj_seq_ctrl
    import obj_pkg::*;
(
    input  logic                    clk96_i,
    input  logic                    reset96_i,
    input  logic                    hb_i,
    input  logic                    vb_i,
    input  logic [LINE_W-1:0]       vrender_i,
    input  logic [RAM_DATA_W-1:0]   ram_data_a_i,
    input  logic [RAM_DATA_W-1:0]   ram_data_b_i,
    input  logic [LINE_W-1:0]       sprite_scroll_x_i,
    input  logic [LINE_W-1:0]       sprite_scroll_y_i,
    input  logic                    match_i,
    input  logic [PRI_W-1:0]        match_pri_i,
    input  logic                    q_empty_i,
    input  logic [PRI_W-1:0]        q_pri_i,
    input  logic [SPR_IDX_W:0]      q_count_i,
    input  logic [SPR_IDX_W-1:0]    q_sprite_i,
    input  logic                    gfx_ok_i,
    input  logic                    slice_done_i,
    output logic [RAM_ADDR_W-1:0]   ram_addr_a_o,
    output logic [RAM_ADDR_W-1:0]   ram_addr_b_o,
    output logic                    q_push_o,
    output logic [SPR_IDX_W-1:0]    q_sprite_o,
    output logic [PRI_W-1:0]        q_rd_pri_o,
    output logic [SPR_IDX_W:0]      q_rd_idx_o,
    output logic                    q_clear_o,
    output logic                    gfx_cs_o,
    output logic [TILE_NUM_W-1:0]   tile_num_o,
    output logic [TILE_OFFS_W-1:0]  tile_offs_o,
    output logic                    slice_load_o,
    output logic                    slice_xflip_o,
    output logic signed [LINE_W:0]  slice_x_o,
    output logic [PRI_W+PAL_W-1:0]  slice_attr_o
);

    seq_state_t             state;
    logic [2:0]             phase;
    logic                   hb_q, pending;
    logic [SPR_IDX_W-1:0]   spr;
    logic [SIZE_W-1:0]      col, size_x, scr_col;
    logic [LINE_W-1:0]      row, x_sum, y_sum;
    logic signed [LINE_W:0] x_base;
    logic [TILE_OFFS_W-1:0] tile_w, offs_n;

    assign x_sum = ram_data_a_i[POS_HI:POS_LO] + sprite_scroll_x_i;  // wraps at 512
    assign y_sum = ram_data_b_i[POS_HI:POS_LO] + sprite_scroll_y_i;

    // row of tiles down, line inside the tile, tile column across
    assign tile_w = TILE_OFFS_W'(size_x) + 1'b1;
    assign offs_n = ((TILE_OFFS_W'(row[LINE_W-1:3]) * tile_w) << 5)
                  + (TILE_OFFS_W'(row[2:0]) << 2) + (TILE_OFFS_W'(col) << 5);

    assign scr_col      = slice_xflip_o ? size_x - col : col;  // flipped sprites mirror columns
    assign slice_x_o    = x_base + $signed({3'b000, scr_col, 3'b000});
    assign slice_load_o = gfx_cs_o & gfx_ok_i;

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            state <= S_IDLE;
            phase <= '0;
            hb_q <= 1'b0;
            pending <= 1'b0;
            spr <= '0;
            col <= '0;
            size_x <= '0;
            row <= '0;
            x_base <= '0;
            ram_addr_a_o <= '0;
            ram_addr_b_o <= '0;
            q_push_o <= 1'b0;
            q_sprite_o <= '0;
            q_rd_pri_o <= '0;
            q_rd_idx_o <= '0;
            q_clear_o <= 1'b0;
            gfx_cs_o <= 1'b0;
            tile_num_o <= '0;
            tile_offs_o <= '0;
            slice_xflip_o <= 1'b0;
            slice_attr_o <= '0;
        end else begin
            hb_q <= hb_i;
            q_push_o <= 1'b0;
            q_clear_o <= 1'b0;
            phase <= phase + 1'b1;
            case (state)
                S_IDLE: begin
                    phase <= '0;
                    if (pending) begin
                        pending <= 1'b0;
                        q_clear_o <= 1'b1;  // empty all levels for the new line
                        q_rd_idx_o <= '0;
                        spr <= '0;
                        state <= S_SCAN;
                    end
                end
                S_SCAN: begin
                    if (phase == 3'd0) begin
                        ram_addr_a_o <= RAM_ADDR_W'({spr, 2'b00});  // word 0
                        ram_addr_b_o <= RAM_ADDR_W'({spr, 2'b11});  // word 3
                    end else if (phase == 3'd2) begin
                        phase <= '0;
                        q_push_o <= match_i;
                        if (match_i) begin
                            q_sprite_o <= spr;
                            q_rd_pri_o <= match_pri_i;
                        end
                        if (spr == SPR_IDX_W'(SPR_COUNT - 1)) state <= S_SEL;
                        spr <= spr + 1'b1;
                    end
                end
                S_SEL: begin
                    if (phase == 3'd1) begin  // retired level has left the search by now
                        phase <= '0;
                        if (q_empty_i) begin
                            state <= S_IDLE;
                        end else begin
                            q_rd_pri_o <= q_pri_i;
                            q_rd_idx_o <= '0;
                            state <= S_ATTR;
                        end
                    end
                end
                S_ATTR: begin
                    case (phase)
                        3'd1: begin  // queue entry is out
                            ram_addr_a_o <= RAM_ADDR_W'({q_sprite_i, 2'b00});
                            ram_addr_b_o <= RAM_ADDR_W'({q_sprite_i, 2'b01});
                        end
                        3'd2: begin
                            ram_addr_a_o <= ram_addr_a_o + 2'd2;
                            ram_addr_b_o <= ram_addr_b_o + 2'd2;
                        end
                        3'd3: begin
                            slice_xflip_o <= ram_data_a_i[XFLIP_BIT];
                            slice_attr_o <= {ram_data_a_i[PRI_HI:PRI_LO],
                                             ram_data_a_i[PAL_HI:PAL_LO]};
                            tile_num_o <= ram_data_b_i[TILE_NUM_W-1:0];
                        end
                        3'd4: begin
                            size_x <= ram_data_a_i[SIZE_HI:SIZE_LO];
                            row <= vrender_i - y_sum;
                            if (x_sum > X_WRAP_LIMIT) x_base <= {1'b0, x_sum} - 10'd512;
                            else x_base <= {1'b0, x_sum};
                            col <= '0;
                            phase <= '0;
                            state <= S_GFX;
                        end
                        default: ;
                    endcase
                end
                S_GFX: begin
                    if (phase == 3'd0) begin
                        gfx_cs_o <= 1'b1;
                        tile_offs_o <= offs_n;
                    end else begin
                        phase <= 3'd1;  // hold the request until ok
                        if (gfx_ok_i) begin
                            gfx_cs_o <= 1'b0;
                            state <= S_DRAW;
                        end
                    end
                end
                S_DRAW: begin
                    phase <= '0;
                    if (slice_done_i) begin
                        if (col == size_x) begin
                            q_rd_idx_o <= q_rd_idx_o + 1'b1;
                            state <= (q_rd_idx_o + 1'b1 == q_count_i) ? S_SEL : S_ATTR;
                        end else begin
                            col <= col + 1'b1;
                            state <= S_GFX;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
            if (hb_q && !hb_i && !vb_i) pending <= 1'b1;  // end of blank, waits while busy
        end
    end

    a_gfx_cs_held: assert property (@(posedge clk96_i) disable iff (reset96_i)
        $fell(gfx_cs_o) |-> $past(gfx_ok_i))
        else $error("gfx_cs_o dropped before gfx_ok_i");

    a_rd_idx_in_range: assert property (@(posedge clk96_i) disable iff (reset96_i)
        (state == S_ATTR && phase == 3'd0) |-> q_rd_idx_o < q_count_i)
        else $error("queue read index past level count");

endmodule

// ==== linebuf/obj_line_buffer.sv ====
module obj_line_buffer
    import obj_pkg::*;
(
    input  logic              clk96_i,
    input  logic              reset96_i,
    input  logic              hb_i,
    input  logic              pixel_cen_i,
    input  logic              active_i,
    input  logic              wr_en_i,
    input  logic [LINE_W-1:0] wr_addr_i,
    input  logic [PIX_W-1:0]  wr_data_i,
    input  logic [LINE_W-1:0] rd_addr_i,
    output logic [PIX_W-1:0]  pixel_o
);

    logic [PIX_W-1:0] mem [2**(LINE_W+1)];  // both halves, top address bit picks the half
    logic             wr_half;              // half being rendered, the other is shown
    logic             hb_q;
    logic             rd_en;

    assign rd_en = pixel_cen_i & active_i;

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            hb_q <= 1'b0;
            wr_half <= 1'b0;
            pixel_o <= '0;
        end else begin
            hb_q <= hb_i;
            if (hb_q && !hb_i) wr_half <= ~wr_half;  // swap at the end of blank
            if (rd_en) pixel_o <= mem[{~wr_half, rd_addr_i}];
        end
    end

    always_ff @(posedge clk96_i) begin
        if (wr_en_i) mem[{wr_half, wr_addr_i}] <= wr_data_i;
        if (rd_en) mem[{~wr_half, rd_addr_i}] <= '0;  // erase behind the read
    end

endmodule

// ==== source/obj_slice_draw.sv ====
module obj_slice_draw
    import obj_pkg::*;
(
    input  logic                   clk96_i,
    input  logic                   reset96_i,
    input  logic                   load_i,
    input  logic [SLICE_W-1:0]     slice_i,
    input  logic                   xflip_i,
    input  logic signed [LINE_W:0] x_base_i,
    input  logic [PRI_W+PAL_W-1:0] attr_i,
    output logic                   done_o,
    output logic                   wr_en_o,
    output logic [LINE_W-1:0]      wr_addr_o,
    output logic [PIX_W-1:0]       wr_data_o
);

    logic [SLICE_W-1:0]     slice_q;
    logic                   flip_q;
    logic signed [LINE_W:0] x_q;
    logic [PRI_W+PAL_W-1:0] attr_q;
    logic                   busy;
    logic [2:0]             pix;      // pixel position inside the slice
    logic [2:0]             nib_sel;
    logic [3:0]             code;
    logic signed [LINE_W:0] col;

    assign nib_sel = flip_q ? 3'd7 - pix : pix;
    assign code    = slice_q[nib_sel*4 +: 4];  // pixel 0 sits in the low nibble
    assign col     = x_q + $signed({1'b0, pix});

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            busy <= 1'b0;
            pix <= '0;
            wr_en_o <= 1'b0;
            done_o <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            done_o <= 1'b0;
            if (load_i) begin
                busy <= 1'b1;
                pix <= '0;
            end else if (busy) begin
                // colour 0 is transparent, lower levels show through
                wr_en_o <= (code != 4'd0) && (col >= 0) && (col < VIS_WIDTH);
                pix <= pix + 1'b1;
                if (pix == 3'd7) begin
                    busy <= 1'b0;
                    done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk96_i) begin
        if (load_i) begin
            slice_q <= slice_i;
            flip_q <= xflip_i;
            x_q <= x_base_i;
            attr_q <= attr_i;
        end
        wr_addr_o <= col[LINE_W-1:0];
        wr_data_o <= {attr_q, code};
    end

endmodule

// ==== queue/obj_pri_queue.sv ====
module obj_pri_queue
    import obj_pkg::*;
(
    input  logic                 clk96_i,
    input  logic                 reset96_i,
    input  logic                 clear_i,
    input  logic                 push_i,
    input  logic [PRI_W-1:0]     push_pri_i,
    input  logic [SPR_IDX_W-1:0] push_sprite_i,
    input  logic [PRI_W-1:0]     rd_pri_i,
    input  logic [SPR_IDX_W:0]   rd_idx_i,
    output logic                 empty_o,
    output logic [PRI_W-1:0]     first_pri_o,
    output logic [SPR_IDX_W:0]   count_o,
    output logic [SPR_IDX_W-1:0] sprite_o
);

    logic [SPR_IDX_W-1:0] mem [PRI_LEVELS*SPR_COUNT];  // level in the top address bits
    logic [SPR_IDX_W:0]   cnt [PRI_LEVELS];
    logic [PRI_LEVELS-1:0] pend;  // level still has sprites to draw

    always_ff @(posedge clk96_i or posedge reset96_i) begin
        if (reset96_i) begin
            pend <= '0;
            for (int i = 0; i < PRI_LEVELS; i++) cnt[i] <= '0;
        end else if (clear_i) begin
            pend <= '0;
            for (int i = 0; i < PRI_LEVELS; i++) cnt[i] <= '0;
        end else begin
            if (push_i) begin
                cnt[push_pri_i] <= cnt[push_pri_i] + 1'b1;
                pend[push_pri_i] <= 1'b1;
            end
            // reader stepped past the last entry
            if (cnt[rd_pri_i] != '0 && rd_idx_i == cnt[rd_pri_i]) pend[rd_pri_i] <= 1'b0;
        end
    end

    always_ff @(posedge clk96_i) begin
        if (push_i) mem[{push_pri_i, cnt[push_pri_i][SPR_IDX_W-1:0]}] <= push_sprite_i;
        sprite_o <= mem[{rd_pri_i, rd_idx_i[SPR_IDX_W-1:0]}];
    end

    always_comb begin
        first_pri_o = '0;
        for (int i = PRI_LEVELS - 1; i >= 0; i--) begin
            if (pend[i]) first_pri_o = PRI_W'(i);  // lowest level wins
        end
    end

    assign empty_o = ~|pend;
    assign count_o = cnt[rd_pri_i];

    a_no_overflow: assert property (@(posedge clk96_i) disable iff (reset96_i)
        (push_i && !clear_i) |-> cnt[push_pri_i] < SPR_COUNT)
        else $error("priority level %0d overflows", push_pri_i);

endmodule

// ==== source/obj_line_match.sv ====
module obj_line_match
    import obj_pkg::*;
(
    input  logic [RAM_DATA_W-1:0] word0_i,
    input  logic [RAM_DATA_W-1:0] word3_i,
    input  logic [LINE_W-1:0]     vrender_i,
    input  logic [LINE_W-1:0]     sprite_scroll_y_i,
    output logic                  match_o,
    output logic [PRI_W-1:0]      pri_o
);

    logic [LINE_W-1:0] y_top;  // scrolled top line
    logic [LINE_W:0]   y_end;  // one past the bottom line, no wrap
    logic [SIZE_W:0]   tiles_down;

    assign y_top      = word3_i[POS_HI:POS_LO] + sprite_scroll_y_i;
    assign tiles_down = {1'b0, word3_i[SIZE_HI:SIZE_LO]} + 1'b1;
    assign y_end      = {1'b0, y_top} + {tiles_down, 3'b000};  // 8 lines per tile

    // sprites starting above line 0 are not clipped, they simply miss
    assign match_o = word0_i[ACTIVE_BIT]
                   && (vrender_i >= y_top)
                   && ({1'b0, vrender_i} < y_end);

    assign pri_o = word0_i[PRI_HI:PRI_LO];

endmodule

// ==== common/obj_pkg.sv ====
package obj_pkg;

    // table and queue sizes
    localparam int SPR_COUNT    = 256;
    localparam int SPR_IDX_W    = 8;
    localparam int PRI_LEVELS   = 16;
    localparam int PRI_W        = 4;

    // sprite RAM mirror
    localparam int RAM_ADDR_W   = 13;
    localparam int RAM_DATA_W   = 16;

    // screen geometry
    localparam int LINE_W       = 9;
    localparam int VIS_WIDTH    = 320;
    localparam int X_WRAP_LIMIT = 384;  // above this x counts as negative

    // graphics port
    localparam int TILE_NUM_W   = 15;
    localparam int TILE_OFFS_W  = 16;
    localparam int SLICE_W      = 32;   // 8 pixels of 4 bits

    localparam int SIZE_W       = 4;
    localparam int PAL_W        = 6;
    localparam int PIX_W        = 14;   // priority, palette, colour code

    // attribute word 0
    localparam int ACTIVE_BIT   = 15;
    localparam int XFLIP_BIT    = 12;
    localparam int PRI_HI       = 11;
    localparam int PRI_LO       = 8;
    localparam int PAL_HI       = 7;
    localparam int PAL_LO       = 2;

    // attribute words 2 and 3, same layout for x and y
    localparam int POS_HI       = 15;
    localparam int POS_LO       = 7;
    localparam int SIZE_HI      = 3;
    localparam int SIZE_LO      = 0;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SCAN,     // 3 cycles per sprite entry
        S_SEL,      // pick lowest pending priority level
        S_ATTR,     // fetch the four attribute words
        S_GFX,      // slice request on the graphics port
        S_DRAW      // wait for the 8 pixel writes
    } seq_state_t;

endpackage
